// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue_control
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/branch_hold.sv ====
module branch_hold import issue_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic taken_issue,
	output logic squash
);

	hold_state_t state;
	hold_state_t state_next;

	always_comb
	begin
		state_next = state;
		case (state)
			hold_idle:
			begin
				if (taken_issue)
					state_next = hold_squash; // Kill the wrong-path slot
			end
			hold_squash:
				state_next = hold_idle; // Exactly one cycle
			default:
				state_next = hold_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state <= hold_idle;
		else
			state <= state_next;
	end

	assign squash = (state == hold_squash);

endmodule

// ==== rtl/instr_decode.sv ====
module instr_decode import issue_pkg::*;
(
	input  word_t       instr,
	input  reg_status_t sr1_status,
	input  reg_status_t sr2_status,
	input  reg_status_t dest_status,
	output decoded_t    dec,
	output rob_tag_t    rob_sr1_addr,
	output rob_tag_t    rob_sr2_addr
);

	opcode_t op;

	assign op = opcode_t'(instr[15:12]);

	always_comb
	begin
		dec.op = op;
		dec.dest = instr[11:9];
		dec.sr1 = instr[8:6];
		dec.sr2 = instr[2:0];
		dec.imm_sel = instr[5];
		dec.sext5 = {{11{instr[4]}}, instr[4:0]};
		dec.adj6 = {{9{instr[5]}}, instr[5:0], 1'b0}; // Word offset
		dec.adj9 = {{6{instr[8]}}, instr[8:0], 1'b0};
		case (op)
			op_add, op_and, op_not: dec.cls = class_alu;
			op_ldr: dec.cls = class_load;
			op_str: dec.cls = class_store;
			op_lea: dec.cls = class_lea;
			op_br: dec.cls = class_branch;
			default: dec.cls = class_none; // Consumed without issue
		endcase
	end

	assign rob_sr1_addr = sr1_status.rob_entry;

	// Second read port serves the store data register on STR
	assign rob_sr2_addr = (op == op_str) ? dest_status.rob_entry : sr2_status.rob_entry;

endmodule

// ==== rtl/issue_control.sv ====
module issue_control import issue_pkg::*;
(
	input  logic                         clk,
	input  logic                         rst,
	input  word_t                        instr,
	input  logic                         instr_is_new,
	input  word_t                        curr_pc,
	input  logic                         predict_taken,
	input  cdb_t                         cdb,
	input  logic [NUM_ALU_STATIONS-1:0] alu_rs_busy,
	input  logic                         ldst_full,
	input  logic                         rob_full,
	input  rob_tag_t                     rob_tail,
	input  rob_lookup_t                  rob_sr1,
	input  rob_lookup_t                  rob_sr2,
	input  reg_status_t                  sr1_status,
	input  reg_status_t                  sr2_status,
	input  reg_status_t                  dest_status,
	output rob_tag_t                     rob_sr1_addr,
	output rob_tag_t                     rob_sr2_addr,
	output logic                         stall,
	output logic                         pcmux_sel,
	output word_t                        br_pc,
	output rs_issue_t                    rs_issue,
	output ldst_issue_t                  ldst_issue,
	output rob_write_t                   rob_write,
	output reg_claim_t                   reg_claim
);

	decoded_t dec;
	operand_t sr1_opnd;
	operand_t sr2_opnd;
	operand_t src_opnd;
	logic     squash;
	logic     taken_issue;

	instr_decode decode0
	(
		.instr        (instr),
		.sr1_status   (sr1_status),
		.sr2_status   (sr2_status),
		.dest_status  (dest_status),
		.dec          (dec),
		.rob_sr1_addr (rob_sr1_addr),
		.rob_sr2_addr (rob_sr2_addr)
	);

	operand_resolve resolve_sr1
	(
		.status (sr1_status),
		.cdb    (cdb),
		.rob    (rob_sr1),
		.opnd   (sr1_opnd)
	);

	operand_resolve resolve_sr2
	(
		.status (sr2_status),
		.cdb    (cdb),
		.rob    (rob_sr2),
		.opnd   (sr2_opnd)
	);

	// Store data comes from the dest field and shares ROB port 2
	operand_resolve resolve_src
	(
		.status (dest_status),
		.cdb    (cdb),
		.rob    (rob_sr2),
		.opnd   (src_opnd)
	);

	branch_hold hold0
	(
		.clk         (clk),
		.rst         (rst),
		.taken_issue (taken_issue),
		.squash      (squash)
	);

	issue_dispatch dispatch0
	(
		.dec           (dec),
		.instr_is_new  (instr_is_new),
		.squash        (squash),
		.curr_pc       (curr_pc),
		.predict_taken (predict_taken),
		.sr1_opnd      (sr1_opnd),
		.sr2_opnd      (sr2_opnd),
		.src_opnd      (src_opnd),
		.alu_rs_busy   (alu_rs_busy),
		.ldst_full     (ldst_full),
		.rob_full      (rob_full),
		.rob_tail      (rob_tail),
		.stall         (stall),
		.taken_issue   (taken_issue),
		.pcmux_sel     (pcmux_sel),
		.br_pc         (br_pc),
		.rs_issue      (rs_issue),
		.ldst_issue    (ldst_issue),
		.rob_write     (rob_write),
		.reg_claim     (reg_claim)
	);

endmodule

// ==== rtl/issue_dispatch.sv ====
module issue_dispatch import issue_pkg::*;
(
	input  decoded_t                     dec,
	input  logic                         instr_is_new,
	input  logic                         squash,
	input  word_t                        curr_pc,
	input  logic                         predict_taken,
	input  operand_t                     sr1_opnd,
	input  operand_t                     sr2_opnd,
	input  operand_t                     src_opnd,
	input  logic [NUM_ALU_STATIONS-1:0] alu_rs_busy,
	input  logic                         ldst_full,
	input  logic                         rob_full,
	input  rob_tag_t                     rob_tail,
	output logic                         stall,
	output logic                         taken_issue,
	output logic                         pcmux_sel,
	output word_t                        br_pc,
	output rs_issue_t                    rs_issue,
	output ldst_issue_t                  ldst_issue,
	output rob_write_t                   rob_write,
	output reg_claim_t                   reg_claim
);

	logic        live;
	logic        is_alu;
	logic        is_mem;
	logic        issue;
	station_id_t alu_station;
	word_t       pc_target;
	operand_t    imm_opnd;

	assign live = instr_is_new && !squash;
	assign is_alu = (dec.cls == class_alu);
	assign is_mem = (dec.cls == class_load) || (dec.cls == class_store);

	// Unsupported opcodes never hold up fetch
	assign stall = live && (dec.cls != class_none) &&
		(rob_full || (is_alu && (&alu_rs_busy)) || (is_mem && ldst_full));

	assign issue = live && !stall;

	// Lowest-numbered free station wins
	always_comb
	begin
		alu_station = '0;
		for (int i = NUM_ALU_STATIONS - 1; i >= 0; i--)
		begin
			if (!alu_rs_busy[i])
				alu_station = station_id_t'(i);
		end
	end

	assign pc_target = curr_pc + dec.adj9; // Shared by LEA and BR

	assign imm_opnd.ready = 1'b1;
	assign imm_opnd.value = dec.sext5;
	assign imm_opnd.tag = '0;

	assign taken_issue = issue && (dec.cls == class_branch) && predict_taken;
	assign pcmux_sel = taken_issue;
	assign br_pc = taken_issue ? pc_target : '0;

	always_comb
	begin
		rs_issue = '0;
		ldst_issue = '0;
		rob_write = '0;
		reg_claim = '0;
		if (issue && (dec.cls != class_none))
		begin
			rob_write.valid = 1'b1;
			rob_write.op = dec.op;
			rob_write.dest = dec.dest;
			case (dec.cls)
				class_alu:
				begin
					rs_issue.valid = 1'b1;
					rs_issue.op = dec.op;
					rs_issue.station = alu_station;
					rs_issue.j = sr1_opnd;
					rs_issue.k = dec.imm_sel ? imm_opnd : sr2_opnd;
					rs_issue.dest = rob_tail;
					reg_claim.valid = 1'b1;
				end
				class_load:
				begin
					ldst_issue.valid = 1'b1;
					ldst_issue.op = dec.op;
					ldst_issue.base = sr1_opnd;
					ldst_issue.offset = dec.adj6;
					ldst_issue.dest = rob_tail;
					reg_claim.valid = 1'b1;
				end
				class_store:
				begin
					ldst_issue.valid = 1'b1;
					ldst_issue.op = dec.op;
					ldst_issue.base = sr1_opnd;
					ldst_issue.src = src_opnd;
					ldst_issue.offset = dec.adj6;
					rob_write.dest = '0; // Stores have no register result
				end
				class_lea:
				begin
					rob_write.value = pc_target;
					reg_claim.valid = 1'b1;
				end
				class_branch:
					rob_write.value = predict_taken ? curr_pc : pc_target; // Recovery PC
				default:
					rob_write.value = '0;
			endcase
			if (reg_claim.valid)
			begin
				reg_claim.dest = dec.dest;
				reg_claim.rob_entry = rob_tail;
			end
		end
	end

endmodule

// ==== rtl/issue_pkg.sv ====
package issue_pkg;

	localparam int NUM_ALU_STATIONS = 3;

	typedef logic [15:0] word_t;      // Data or address word
	typedef logic [2:0]  reg_idx_t;   // Architectural register number
	typedef logic [2:0]  rob_tag_t;   // ROB entry number
	typedef logic [1:0]  station_id_t; // ALU reservation station number

	typedef enum logic [3:0]
	{
		op_br   = 4'd0,
		op_add  = 4'd1,
		op_ldb  = 4'd2,
		op_stb  = 4'd3,
		op_jsr  = 4'd4,
		op_and  = 4'd5,
		op_ldr  = 4'd6,
		op_str  = 4'd7,
		op_rti  = 4'd8,
		op_not  = 4'd9,
		op_ldi  = 4'd10,
		op_sti  = 4'd11,
		op_jmp  = 4'd12,
		op_shf  = 4'd13,
		op_lea  = 4'd14,
		op_trap = 4'd15
	} opcode_t;

	typedef enum logic [2:0]
	{
		class_alu,
		class_load,
		class_store,
		class_lea,
		class_branch,
		class_none
	} instr_class_t;

	typedef enum logic
	{
		hold_idle,
		hold_squash
	} hold_state_t;

	typedef struct packed
	{
		logic     busy;
		word_t    data;
		rob_tag_t rob_entry; // Producer of the pending value
	} reg_status_t;

	typedef struct packed
	{
		logic     valid;
		rob_tag_t tag;
		word_t    data;
	} cdb_t;

	typedef struct packed
	{
		logic  valid;
		word_t value;
	} rob_lookup_t;

	typedef struct packed
	{
		logic     ready;
		word_t    value; // Zero while waiting
		rob_tag_t tag;
	} operand_t;

	typedef struct packed
	{
		logic        valid;
		opcode_t     op;
		station_id_t station;
		operand_t    j;
		operand_t    k;
		rob_tag_t    dest;
	} rs_issue_t;

	typedef struct packed
	{
		logic     valid;
		opcode_t  op;
		operand_t base;
		operand_t src; // Store data
		word_t    offset;
		rob_tag_t dest;
	} ldst_issue_t;

	typedef struct packed
	{
		logic     valid;
		opcode_t  op;
		reg_idx_t dest;
		word_t    value;
	} rob_write_t;

	typedef struct packed
	{
		logic     valid;
		reg_idx_t dest;
		rob_tag_t rob_entry;
	} reg_claim_t;

	typedef struct packed
	{
		opcode_t      op;
		instr_class_t cls;
		reg_idx_t     dest;
		reg_idx_t     sr1;
		reg_idx_t     sr2;
		logic         imm_sel; // instr[5]
		word_t        sext5;
		word_t        adj6;
		word_t        adj9;
	} decoded_t;

endpackage

// ==== rtl/operand_resolve.sv ====
module operand_resolve import issue_pkg::*;
(
	input  reg_status_t status,
	input  cdb_t        cdb,
	input  rob_lookup_t rob,
	output operand_t    opnd
);

	logic cdb_hit;

	assign cdb_hit = cdb.valid && (cdb.tag == status.rob_entry);

	always_comb
	begin
		opnd.ready = 1'b1;
		opnd.tag = '0;
		if (!status.busy)
			opnd.value = status.data; // Register file holds it
		else if (cdb_hit)
			opnd.value = cdb.data; // Broadcast this cycle
		else if (rob.valid)
			opnd.value = rob.value; // Finished but not retired
		else
		begin
			// Still in flight, wait on the producer tag
			opnd.ready = 1'b0;
			opnd.value = '0;
			opnd.tag = status.rob_entry;
		end
	end

endmodule

// ==== sources.f ====
+incdir+tb
rtl/issue_pkg.sv
rtl/instr_decode.sv
rtl/operand_resolve.sv
rtl/branch_hold.sv
rtl/issue_dispatch.sv
rtl/issue_control.sv
tb/tb_issue_control.sv

// ==== tb/issue_ref.svh ====
`ifndef ISSUE_REF_SVH
`define ISSUE_REF_SVH

typedef struct packed
{
	word_t                       instr;
	logic                        instr_is_new;
	word_t                       curr_pc;
	logic                        predict_taken;
	cdb_t                        cdb;
	logic [NUM_ALU_STATIONS-1:0] alu_rs_busy;
	logic                        ldst_full;
	logic                        rob_full;
	rob_tag_t                    rob_tail;
	rob_lookup_t                 rob_sr1;
	rob_lookup_t                 rob_sr2;
	reg_status_t                 sr1_status;
	reg_status_t                 sr2_status;
	reg_status_t                 dest_status;
} stim_t;

typedef struct packed
{
	logic        stall;
	logic        pcmux_sel;
	word_t       br_pc;
	rob_tag_t    rob_sr1_addr;
	rob_tag_t    rob_sr2_addr;
	rs_issue_t   rs_issue;
	ldst_issue_t ldst_issue;
	rob_write_t  rob_write;
	reg_claim_t  reg_claim;
} expected_t;

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
	if (state[0])
		return (state >> 1) ^ 32'h8020_0003; // Galois taps
	return state >> 1;
endfunction

// Register first, then CDB, then ROB, else wait on the tag
function automatic operand_t resolve_ref(input reg_status_t st, input cdb_t c,
	input rob_lookup_t r);
	operand_t o;
	o = '0;
	o.ready = 1'b1;
	if (!st.busy)
		o.value = st.data;
	else if (c.valid && (c.tag == st.rob_entry))
		o.value = c.data;
	else if (r.valid)
		o.value = r.value;
	else
	begin
		o.ready = 1'b0;
		o.tag = st.rob_entry;
	end
	return o;
endfunction

function automatic expected_t issue_ref(input stim_t s, input logic squash);
	expected_t  e;
	logic [3:0] op;
	int         imm5;
	int         off6;
	int         off9;
	logic       alu_op;
	logic       mem_op;
	logic       kept;
	logic       live;
	word_t      target;
	e = '0;
	op = s.instr[15:12];
	imm5 = int'(s.instr[4:0]);
	off6 = int'(s.instr[5:0]);
	off9 = int'(s.instr[8:0]);
	if (imm5 > 15)
		imm5 = imm5 - 32;
	if (off6 > 31)
		off6 = off6 - 64;
	if (off9 > 255)
		off9 = off9 - 512;
	target = s.curr_pc + word_t'(off9 * 2);
	alu_op = (op == 4'd1) || (op == 4'd5) || (op == 4'd9);
	mem_op = (op == 4'd6) || (op == 4'd7);
	kept = alu_op || mem_op || (op == 4'd14) || (op == 4'd0);
	e.rob_sr1_addr = s.sr1_status.rob_entry;
	e.rob_sr2_addr = (op == 4'd7) ? s.dest_status.rob_entry : s.sr2_status.rob_entry;
	live = s.instr_is_new && !squash;
	e.stall = live && kept && (s.rob_full || (alu_op && (s.alu_rs_busy == 3'b111)) ||
		(mem_op && s.ldst_full));
	if (!live || e.stall || !kept)
		return e;
	e.rob_write.valid = 1'b1;
	e.rob_write.op = opcode_t'(op);
	e.rob_write.dest = (op == 4'd7) ? 3'd0 : s.instr[11:9];
	if (alu_op)
	begin
		e.rs_issue.valid = 1'b1;
		e.rs_issue.op = opcode_t'(op);
		if (!s.alu_rs_busy[0])
			e.rs_issue.station = 2'd0;
		else if (!s.alu_rs_busy[1])
			e.rs_issue.station = 2'd1;
		else
			e.rs_issue.station = 2'd2;
		e.rs_issue.j = resolve_ref(s.sr1_status, s.cdb, s.rob_sr1);
		if (s.instr[5])
		begin
			e.rs_issue.k.ready = 1'b1; // Immediate form
			e.rs_issue.k.value = word_t'(imm5);
		end
		else
			e.rs_issue.k = resolve_ref(s.sr2_status, s.cdb, s.rob_sr2);
		e.rs_issue.dest = s.rob_tail;
	end
	if (mem_op)
	begin
		e.ldst_issue.valid = 1'b1;
		e.ldst_issue.op = opcode_t'(op);
		e.ldst_issue.base = resolve_ref(s.sr1_status, s.cdb, s.rob_sr1);
		e.ldst_issue.offset = word_t'(off6 * 2);
		if (op == 4'd6)
			e.ldst_issue.dest = s.rob_tail;
		else
			e.ldst_issue.src = resolve_ref(s.dest_status, s.cdb, s.rob_sr2);
	end
	if (op == 4'd14)
		e.rob_write.value = target;
	if (op == 4'd0)
	begin
		e.rob_write.value = s.predict_taken ? s.curr_pc : target;
		e.pcmux_sel = s.predict_taken;
		e.br_pc = s.predict_taken ? target : 16'd0;
	end
	if (alu_op || (op == 4'd6) || (op == 4'd14))
	begin
		e.reg_claim.valid = 1'b1;
		e.reg_claim.dest = s.instr[11:9];
		e.reg_claim.rob_entry = s.rob_tail;
	end
	return e;
endfunction

`endif

// ==== tb/tb_issue_control.sv ====
module tb_issue_control import issue_pkg::*;
();

	`include "issue_ref.svh"

	logic        clk = 1'b0;
	logic        rst;
	logic        running;      // Random slots enabled
	logic        model_squash; // Expected branch_hold state
	logic [31:0] lfsr;
	stim_t       drv;
	expected_t   exp_now;
	int          check_count;
	int          error_count;
	int          timeout_count;
	int          taken_count;
	int          squash_count;
	int          stall_count;

	rob_tag_t    rob_sr1_addr;
	rob_tag_t    rob_sr2_addr;
	logic        stall;
	logic        pcmux_sel;
	word_t       br_pc;
	rs_issue_t   rs_issue;
	ldst_issue_t ldst_issue;
	rob_write_t  rob_write;
	reg_claim_t  reg_claim;

	issue_control dut0
	(
		.clk           (clk),
		.rst           (rst),
		.instr         (drv.instr),
		.instr_is_new  (drv.instr_is_new),
		.curr_pc       (drv.curr_pc),
		.predict_taken (drv.predict_taken),
		.cdb           (drv.cdb),
		.alu_rs_busy   (drv.alu_rs_busy),
		.ldst_full     (drv.ldst_full),
		.rob_full      (drv.rob_full),
		.rob_tail      (drv.rob_tail),
		.rob_sr1       (drv.rob_sr1),
		.rob_sr2       (drv.rob_sr2),
		.sr1_status    (drv.sr1_status),
		.sr2_status    (drv.sr2_status),
		.dest_status   (drv.dest_status),
		.rob_sr1_addr  (rob_sr1_addr),
		.rob_sr2_addr  (rob_sr2_addr),
		.stall         (stall),
		.pcmux_sel     (pcmux_sel),
		.br_pc         (br_pc),
		.rs_issue      (rs_issue),
		.ldst_issue    (ldst_issue),
		.rob_write     (rob_write),
		.reg_claim     (reg_claim)
	);

	always #2 clk = !clk; // Period of 4

	task automatic take_bits(input int n, output logic [31:0] bits);
		bits = '0;
		for (int i = 0; i < n; i++)
		begin
			bits = {bits[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic make_stim(output stim_t s);
		logic [31:0] r;
		logic [3:0]  op;
		take_bits(3, r);
		case (r[2:0])
			3'd0: op = 4'd1;  // ADD
			3'd1: op = 4'd5;  // AND
			3'd2: op = 4'd9;  // NOT
			3'd3: op = 4'd6;  // LDR
			3'd4: op = 4'd7;  // STR
			3'd5: op = 4'd14; // LEA
			3'd6: op = 4'd0;  // BR
			default:
			begin
				take_bits(4, r);
				op = r[3:0]; // Any opcode at all
			end
		endcase
		take_bits(12, r);
		s.instr = {op, r[11:0]};
		take_bits(3, r);
		s.instr_is_new = (r[2:0] != 3'd0);
		take_bits(16, r);
		s.curr_pc = r[15:0];
		take_bits(1, r);
		s.predict_taken = r[0];
		take_bits(3, r);
		s.alu_rs_busy = r[2:0];
		take_bits(2, r);
		s.ldst_full = (r[1:0] == 2'd0);
		take_bits(3, r);
		s.rob_full = (r[2:0] == 3'd0);
		take_bits(3, r);
		s.rob_tail = r[2:0];
		take_bits(20, r);
		s.sr1_status = reg_status_t'(r[19:0]);
		take_bits(20, r);
		s.sr2_status = reg_status_t'(r[19:0]);
		take_bits(20, r);
		s.dest_status = reg_status_t'(r[19:0]);
		take_bits(17, r);
		s.rob_sr1 = rob_lookup_t'(r[16:0]);
		take_bits(17, r);
		s.rob_sr2 = rob_lookup_t'(r[16:0]);
		take_bits(2, r);
		case (r[1:0]) // Steer CDB tag toward pending producers
			2'd0: s.cdb.tag = s.sr1_status.rob_entry;
			2'd1: s.cdb.tag = s.sr2_status.rob_entry;
			2'd2: s.cdb.tag = s.dest_status.rob_entry;
			default:
			begin
				take_bits(3, r);
				s.cdb.tag = r[2:0];
			end
		endcase
		take_bits(17, r);
		s.cdb.valid = r[16];
		s.cdb.data = r[15:0];
	endtask

	task automatic check_value(input string what, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected)
		begin
			error_count++;
			$display("mismatch at time %0t: %s is %0h, expected %0h",
				$time, what, actual, expected);
		end
	endtask

	always @(posedge clk)
	begin
		stim_t s;
		make_stim(s);
		if (!running)
			s.instr_is_new = 1'b0; // Idle slots through reset
		drv <= s;
	end

	always @(posedge clk)
	begin
		if (rst)
			model_squash <= 1'b0;
		else
			model_squash <= exp_now.pcmux_sel; // Slot after a taken BR
	end

	always @(negedge clk)
	begin
		exp_now = issue_ref(drv, model_squash);
		check_value("stall", 128'(stall), 128'(exp_now.stall));
		check_value("pcmux_sel", 128'(pcmux_sel), 128'(exp_now.pcmux_sel));
		check_value("br_pc", 128'(br_pc), 128'(exp_now.br_pc));
		check_value("rob_sr1_addr", 128'(rob_sr1_addr), 128'(exp_now.rob_sr1_addr));
		check_value("rob_sr2_addr", 128'(rob_sr2_addr), 128'(exp_now.rob_sr2_addr));
		check_value("rs_issue", 128'(rs_issue), 128'(exp_now.rs_issue));
		check_value("ldst_issue", 128'(ldst_issue), 128'(exp_now.ldst_issue));
		check_value("rob_write", 128'(rob_write), 128'(exp_now.rob_write));
		check_value("reg_claim", 128'(reg_claim), 128'(exp_now.reg_claim));
		check_count++;
		if (exp_now.pcmux_sel)
			taken_count++;
		if (model_squash && drv.instr_is_new)
			squash_count++;
		if (exp_now.stall)
			stall_count++;
	end

	initial
	begin
		int wait_cycles;
		rst = 1'b1;
		running = 1'b0;
		model_squash = 1'b0;
		lfsr = 32'h57c;
		drv = '0;
		exp_now = '0;
		check_count = 0;
		error_count = 0;
		timeout_count = 0;
		taken_count = 0;
		squash_count = 0;
		stall_count = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		repeat (4) @(posedge clk); // Quiet slots right after reset
		running <= 1'b1;
		wait_cycles = 0;
		while ((check_count < 2000) && (wait_cycles < 3000))
		begin
			@(posedge clk);
			wait_cycles++;
		end
		if (check_count < 2000)
		begin
			timeout_count++;
			$display("Timeout: the checker did not reach 2000 compared cycles");
		end
		if ((taken_count == 0) || (squash_count == 0) || (stall_count == 0))
		begin
			error_count++;
			$display("Random stimulus missed taken branches, squashed slots or stalls");
		end
		$display("Checks %0d, errors %0d, timeouts %0d, taken %0d, squashed %0d, stalls %0d",
			check_count, error_count, timeout_count, taken_count, squash_count, stall_count);
		if ((error_count == 0) && (timeout_count == 0))
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
